//--- hw/sbus_defs.svh
// Widths and timing constants of the serial bus.
// The Wishbone address is the node id on top of the local address.
// All values are single numbers; SBUS_TURN_CYCLES must be at least 1.
`ifndef SBUS_DEFS_SVH
`define SBUS_DEFS_SVH

// ------------------------------
// Field widths
// ------------------------------
`define SBUS_ID_W         2
`define SBUS_ADDR_W       8
`define SBUS_DATA_W       8
`define SBUS_WB_ADR_W     (`SBUS_ID_W + `SBUS_ADDR_W)

// ------------------------------
// Build and timing
// ------------------------------
`define SBUS_NUM_NODES    3
`define SBUS_TURN_CYCLES  2    // Idle cycles before a node answers.
`define SBUS_RESP_TIMEOUT 16   // Cycles the receiver waits for a start bit.

`endif

//--- hw/sbus_pkg.sv
// Opcode and FSM state types shared by the bus blocks.
`default_nettype none

package sbus_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } sbus_op_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_SHIFT = 2'd1,
        TX_WAIT  = 2'd2
    } tx_state_e;

    typedef enum logic [2:0] {
        N_IDLE   = 3'd0,
        N_HEADER = 3'd1,
        N_ADDR   = 3'd2,
        N_DATA   = 3'd3,
        N_SKIP   = 3'd4,
        N_ACCESS = 3'd5,
        N_TURN   = 3'd6,
        N_REPLY  = 3'd7
    } node_state_e;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_ARMED = 2'd1,
        RX_DATA  = 2'd2,
        RX_DONE  = 2'd3
    } rx_state_e;

endpackage

`default_nettype wire

//--- hw/sbus_frame_tx.sv
// Wishbone classic slave front end; one frame per bus cycle.
// The host must hold its inputs stable until ack or err.
// A new cycle is taken only after resp_done, so frames never overlap.
`timescale 1ns/1ps
`default_nettype none

`include "sbus_defs.svh"

module sbus_frame_tx (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  wire [`SBUS_WB_ADR_W-1:0]   wb_adr,
    input  wire [`SBUS_DATA_W-1:0]     wb_dat_w,
    input  wire                        resp_done,
    output logic                       down_line,
    output logic                       frame_end,
    output logic                       expect_read
);

    localparam int READ_BITS  = 1 + `SBUS_ID_W + 1 + `SBUS_ADDR_W;
    localparam int WRITE_BITS = READ_BITS + `SBUS_DATA_W;
    localparam int CNT_W      = $clog2(WRITE_BITS + 1);
    localparam int SR_W       = WRITE_BITS - 1;   // Start bit is not stored.

    sbus_pkg::tx_state_e  state;
    sbus_pkg::sbus_op_e   op_in;
    logic [CNT_W-1:0]     bit_cnt;
    logic [CNT_W-1:0]     last_bit;
    logic [SR_W-1:0]      frame_sr;
    logic                 start;

    assign start    = wb_cyc && wb_stb;
    assign op_in    = wb_we ? sbus_pkg::OP_WRITE : sbus_pkg::OP_READ;
    assign last_bit = expect_read ? CNT_W'(READ_BITS) : CNT_W'(WRITE_BITS);

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= sbus_pkg::TX_IDLE;
            bit_cnt     <= '0;
            down_line   <= 1'b1;
            frame_end   <= 1'b0;
            expect_read <= 1'b0;
        end else begin
            frame_end <= 1'b0;
            case (state)
                sbus_pkg::TX_IDLE: begin
                    if (start) begin
                        down_line   <= 1'b0;   // Start bit.
                        bit_cnt     <= CNT_W'(1);
                        expect_read <= (op_in == sbus_pkg::OP_READ);
                        state       <= sbus_pkg::TX_SHIFT;
                    end
                end
                sbus_pkg::TX_SHIFT: begin
                    if (bit_cnt == last_bit) begin
                        down_line <= 1'b1;
                        frame_end <= 1'b1;
                        state     <= sbus_pkg::TX_WAIT;
                    end else begin
                        down_line <= frame_sr[SR_W-1];
                        bit_cnt   <= bit_cnt + 1'b1;
                    end
                end
                sbus_pkg::TX_WAIT: begin
                    if (resp_done) begin
                        state <= sbus_pkg::TX_IDLE;
                    end
                end
                default: state <= sbus_pkg::TX_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Frame shift register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (state == sbus_pkg::TX_IDLE && start) begin
            frame_sr <= {wb_adr[`SBUS_WB_ADR_W-1:`SBUS_ADDR_W], op_in,
                         wb_adr[`SBUS_ADDR_W-1:0], wb_dat_w};
        end else if (state == sbus_pkg::TX_SHIFT) begin
            frame_sr <= {frame_sr[SR_W-2:0], 1'b0};   // MSB first.
        end
    end

endmodule

`default_nettype wire

//--- hw/sbus_node.sv
// One bus node with a private 256-byte memory.
// Every node follows every frame so it can skip frames for its peers.
// Memory contents are undefined after reset.
// up_drive is an open-drain output, 1 means released.
`timescale 1ns/1ps
`default_nettype none

`include "sbus_defs.svh"

module sbus_node #(
    parameter int NODE_ID = 0
) (
    input  wire   clk,
    input  wire   rstn,
    input  wire   down_line,
    output logic  up_drive
);

    localparam logic [`SBUS_ID_W-1:0] MY_ID = `SBUS_ID_W'(NODE_ID);
    localparam int CNT_W = $clog2(`SBUS_ADDR_W + `SBUS_DATA_W + 1);
    localparam int DEPTH = 2 ** `SBUS_ADDR_W;

    sbus_pkg::node_state_e    state;
    sbus_pkg::sbus_op_e       op;
    logic [CNT_W-1:0]         cnt;
    logic [CNT_W-1:0]         skip_last;
    logic [`SBUS_ID_W-1:0]    id_sr;
    logic [`SBUS_ADDR_W-1:0]  addr;
    logic [`SBUS_DATA_W-1:0]  wdata;
    logic [`SBUS_DATA_W-1:0]  rdata;
    logic [`SBUS_DATA_W-1:0]  mem [DEPTH];
    logic                     send_data;

    // Bits left after the opcode in a frame for another node.
    assign skip_last = (op == sbus_pkg::OP_WRITE) ?
                       CNT_W'(`SBUS_ADDR_W + `SBUS_DATA_W - 1) : CNT_W'(`SBUS_ADDR_W - 1);
    assign send_data = (op == sbus_pkg::OP_READ) && (cnt < CNT_W'(`SBUS_DATA_W));

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= sbus_pkg::N_IDLE;
            op       <= sbus_pkg::OP_READ;
            cnt      <= '0;
            id_sr    <= '0;
            up_drive <= 1'b1;
        end else begin
            case (state)
                sbus_pkg::N_IDLE: begin
                    if (!down_line) begin
                        cnt   <= '0;
                        state <= sbus_pkg::N_HEADER;
                    end
                end
                sbus_pkg::N_HEADER: begin
                    if (cnt == CNT_W'(`SBUS_ID_W)) begin
                        op  <= sbus_pkg::sbus_op_e'(down_line);
                        cnt <= '0;
                        if (id_sr == MY_ID) begin
                            state <= sbus_pkg::N_ADDR;
                        end else begin
                            state <= sbus_pkg::N_SKIP;
                        end
                    end else begin
                        id_sr <= {id_sr[`SBUS_ID_W-2:0], down_line};
                        cnt   <= cnt + 1'b1;
                    end
                end
                sbus_pkg::N_ADDR: begin
                    if (cnt == CNT_W'(`SBUS_ADDR_W - 1)) begin
                        cnt   <= '0;
                        state <= (op == sbus_pkg::OP_WRITE) ? sbus_pkg::N_DATA
                                                            : sbus_pkg::N_ACCESS;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sbus_pkg::N_DATA: begin
                    if (cnt == CNT_W'(`SBUS_DATA_W - 1)) begin
                        cnt   <= '0;
                        state <= sbus_pkg::N_ACCESS;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sbus_pkg::N_SKIP: begin
                    if (cnt == skip_last) begin
                        state <= sbus_pkg::N_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sbus_pkg::N_ACCESS: begin
                    cnt   <= '0;
                    state <= sbus_pkg::N_TURN;
                end
                sbus_pkg::N_TURN: begin
                    if (cnt == CNT_W'(`SBUS_TURN_CYCLES - 1)) begin
                        up_drive <= 1'b0;   // Response start bit.
                        cnt      <= '0;
                        state    <= sbus_pkg::N_REPLY;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sbus_pkg::N_REPLY: begin
                    if (send_data) begin
                        up_drive <= rdata[`SBUS_DATA_W-1];
                        cnt      <= cnt + 1'b1;
                    end else begin
                        up_drive <= 1'b1;
                        state    <= sbus_pkg::N_IDLE;
                    end
                end
                default: state <= sbus_pkg::N_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Datapath and memory
    // ------------------------------
    always_ff @(posedge clk) begin
        case (state)
            sbus_pkg::N_ADDR: addr  <= {addr[`SBUS_ADDR_W-2:0], down_line};
            sbus_pkg::N_DATA: wdata <= {wdata[`SBUS_DATA_W-2:0], down_line};
            sbus_pkg::N_ACCESS: begin
                if (op == sbus_pkg::OP_WRITE) begin
                    mem[addr] <= wdata;
                end else begin
                    rdata <= mem[addr];
                end
            end
            sbus_pkg::N_REPLY: begin
                if (send_data) begin
                    rdata <= {rdata[`SBUS_DATA_W-2:0], 1'b0};
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/sbus_resp_rx.sv
// Response receiver; the up line is the AND of all node outputs.
// A cycle ends with ack on a response or with err after the timeout.
// wb_dat_r keeps the last read byte until the next read completes.
`timescale 1ns/1ps
`default_nettype none

`include "sbus_defs.svh"

module sbus_resp_rx (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire [`SBUS_NUM_NODES-1:0]    up_drive,
    input  wire                          frame_end,
    input  wire                          expect_read,
    output logic [`SBUS_DATA_W-1:0]      wb_dat_r,
    output logic                         wb_ack,
    output logic                         wb_err,
    output logic                         resp_done
);

    localparam int TMR_W = $clog2(`SBUS_RESP_TIMEOUT + 1);
    localparam int BIT_W = $clog2(`SBUS_DATA_W);

    sbus_pkg::rx_state_e      state;
    logic [TMR_W-1:0]         timer;
    logic [BIT_W-1:0]         bit_cnt;
    logic [`SBUS_DATA_W-2:0]  data_sr;
    logic                     up_line;

    assign up_line = &up_drive;   // Wired-AND.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= sbus_pkg::RX_IDLE;
            timer     <= '0;
            bit_cnt   <= '0;
            wb_dat_r  <= '0;
            wb_ack    <= 1'b0;
            wb_err    <= 1'b0;
            resp_done <= 1'b0;
        end else begin
            wb_ack    <= 1'b0;
            wb_err    <= 1'b0;
            resp_done <= 1'b0;
            case (state)
                sbus_pkg::RX_IDLE: begin
                    if (frame_end) begin
                        timer <= '0;
                        state <= sbus_pkg::RX_ARMED;
                    end
                end
                sbus_pkg::RX_ARMED: begin
                    if (!up_line) begin
                        if (expect_read) begin
                            bit_cnt <= '0;
                            state   <= sbus_pkg::RX_DATA;
                        end else begin
                            wb_ack    <= 1'b1;
                            resp_done <= 1'b1;
                            state     <= sbus_pkg::RX_DONE;
                        end
                    end else if (timer == TMR_W'(`SBUS_RESP_TIMEOUT - 1)) begin
                        wb_err    <= 1'b1;   // No node answered.
                        resp_done <= 1'b1;
                        state     <= sbus_pkg::RX_DONE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                sbus_pkg::RX_DATA: begin
                    if (bit_cnt == BIT_W'(`SBUS_DATA_W - 1)) begin
                        wb_dat_r  <= {data_sr, up_line};
                        wb_ack    <= 1'b1;
                        resp_done <= 1'b1;
                        state     <= sbus_pkg::RX_DONE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                sbus_pkg::RX_DONE: state <= sbus_pkg::RX_IDLE;
                default:           state <= sbus_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sbus_pkg::RX_DATA) begin
            data_sr <= {data_sr[`SBUS_DATA_W-3:0], up_line};   // MSB first.
        end
    end

endmodule

`default_nettype wire

//--- hw/sbus_top.sv
// Serial bus top: Wishbone classic slave, frame transmitter, nodes, receiver.
// Node id 3 has no node behind it, so its cycles end with err.
`timescale 1ns/1ps
`default_nettype none

`include "sbus_defs.svh"

module sbus_top (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  wire [`SBUS_WB_ADR_W-1:0]   wb_adr,
    input  wire [`SBUS_DATA_W-1:0]     wb_dat_w,
    output wire [`SBUS_DATA_W-1:0]     wb_dat_r,
    output wire                        wb_ack,
    output wire                        wb_err
);

    wire                        down_line;
    wire                        frame_end;
    wire                        expect_read;
    wire                        resp_done;
    wire [`SBUS_NUM_NODES-1:0]  up_drive;

    sbus_frame_tx u_tx (
        .clk         (clk),
        .rstn        (rstn),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .resp_done   (resp_done),
        .down_line   (down_line),
        .frame_end   (frame_end),
        .expect_read (expect_read)
    );

    for (genvar i = 0; i < `SBUS_NUM_NODES; i++) begin : g_node
        sbus_node #(
            .NODE_ID (i)
        ) u_node (
            .clk       (clk),
            .rstn      (rstn),
            .down_line (down_line),
            .up_drive  (up_drive[i])
        );
    end

    sbus_resp_rx u_rx (
        .clk         (clk),
        .rstn        (rstn),
        .up_drive    (up_drive),
        .frame_end   (frame_end),
        .expect_read (expect_read),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .wb_err      (wb_err),
        .resp_done   (resp_done)
    );

endmodule

`default_nettype wire

//--- verification/sbus_sva.sv
// Protocol assertions on the serial bus top, attached with bind.
// Checks are disabled while rstn is low.
`timescale 1ns/1ps
`default_nettype none

`include "sbus_defs.svh"

module sbus_sva (
    input wire                             clk,
    input wire                             rstn,
    input wire                             wb_cyc,
    input wire                             wb_stb,
    input wire                             wb_ack,
    input wire                             wb_err,
    input wire [`SBUS_NUM_NODES-1:0]       up_drive,
    input wire                             down_line,
    input wire sbus_pkg::tx_state_e        tx_state
);

    ack_err_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(wb_ack && wb_err))
        else $error("wb_ack and wb_err high together");

    end_inside_cycle: assert property (@(posedge clk) disable iff (!rstn)
        (wb_ack || wb_err) |-> (wb_cyc && wb_stb))
        else $error("cycle end outside an active Wishbone cycle");

    single_up_driver: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(~up_drive))
        else $error("more than one node drives the up line");

    idle_down_line: assert property (@(posedge clk) disable iff (!rstn)
        (tx_state == sbus_pkg::TX_IDLE) |-> down_line)
        else $error("down line low while the transmitter is idle");

endmodule

bind sbus_top sbus_sva u_sva (
    .clk       (clk),
    .rstn      (rstn),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .wb_err    (wb_err),
    .up_drive  (up_drive),
    .down_line (down_line),
    .tx_state  (u_tx.state)
);

`default_nettype wire

//--- verification/sbus_tb.sv
// Testbench for the serial bus top; one Wishbone cycle at a time.
// Reads in the stimulus only target addresses written earlier.
`timescale 1ns/1ps
`default_nettype none

`include "sbus_defs.svh"

module sbus_tb;

    typedef enum logic [1:0] {
        END_NONE,
        END_ACK,
        END_ERR
    } end_kind_e;

    localparam int NUM_OPS     = 71;
    localparam int CLK_NS      = 4;
    localparam int WATCHDOG_NS = NUM_OPS * (20 + `SBUS_RESP_TIMEOUT + 12) * CLK_NS + 200;
    localparam int NUM_IDS     = 2 ** `SBUS_ID_W;
    localparam int DEPTH       = 2 ** `SBUS_ADDR_W;

    logic                        clk;
    logic                        rstn;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [`SBUS_WB_ADR_W-1:0]   wb_adr;
    logic [`SBUS_DATA_W-1:0]     wb_dat_w;
    wire  [`SBUS_DATA_W-1:0]     wb_dat_r;
    wire                         wb_ack;
    wire                         wb_err;

    logic [`SBUS_DATA_W-1:0]     model_mem [NUM_IDS][DEPTH];
    bit                          written [NUM_IDS][DEPTH];
    logic [`SBUS_WB_ADR_W-1:0]   written_q [$];

    end_kind_e                   exp_end;
    logic [`SBUS_DATA_W-1:0]     exp_data;
    logic                        exp_read;
    int                          data_errors;
    int                          end_errors;
    int                          other_errors;
    int                          ops_issued;
    int                          ends_seen;

    sbus_top dut0 (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ------------------------------
    // Reference model and checks
    // ------------------------------
    function automatic logic [`SBUS_DATA_W-1:0] predict_read(
        input logic [`SBUS_ID_W-1:0]   id,
        input logic [`SBUS_ADDR_W-1:0] addr
    );
        return model_mem[id][addr];   // Last byte written to that node.
    endfunction

    task automatic check_data(input logic [`SBUS_DATA_W-1:0] got,
                              input logic [`SBUS_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            data_errors++;
            $display("FAIL %0t: %s at adr 0x%0h is 0x%0h, expected 0x%0h",
                     $time, what, wb_adr, got, exp);
        end
    endtask

    task automatic check_end(input end_kind_e got, input end_kind_e exp, input string what);
        if (got !== exp) begin
            end_errors++;
            $display("FAIL %0t: %s at adr 0x%0h is %s, expected %s",
                     $time, what, wb_adr, got.name(), exp.name());
        end
    endtask

    always @(posedge clk) begin
        end_kind_e got_end;
        if (rstn && (wb_ack || wb_err)) begin
            got_end = wb_err ? END_ERR : END_ACK;
            ends_seen++;
            if (!(wb_cyc && wb_stb)) begin
                other_errors++;
                $display("ERROR %0t: the bus ended a cycle that the host never started", $time);
            end
            check_end(got_end, exp_end, "cycle end");
            if (exp_read && got_end == END_ACK) begin
                check_data(wb_dat_r, exp_data, "read data");
            end
        end
    end

    // ------------------------------
    // Wishbone driver
    // ------------------------------
    task automatic wb_access(input sbus_pkg::sbus_op_e op, input logic [`SBUS_ID_W-1:0] id,
                             input logic [`SBUS_ADDR_W-1:0] addr,
                             input logic [`SBUS_DATA_W-1:0] data);
        @(posedge clk);
        exp_read = (op == sbus_pkg::OP_READ);
        exp_end  = (id < `SBUS_NUM_NODES) ? END_ACK : END_ERR;
        exp_data = exp_read ? predict_read(id, addr) : '0;
        if (!exp_read && id < `SBUS_NUM_NODES) begin
            model_mem[id][addr] = data;
            if (!written[id][addr]) begin
                written_q.push_back({id, addr});
            end
            written[id][addr] = 1'b1;
        end
        ops_issued++;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= !exp_read;
        wb_adr   <= {id, addr};
        wb_dat_w <= data;
        do begin
            @(posedge clk);
        end while (!(wb_ack || wb_err));
        wb_cyc <= 1'b0;   // Drop on the edge that sees the end.
        wb_stb <= 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: bus hung, a cycle got neither ack nor err in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int                          seed_val;
        logic [`SBUS_ID_W-1:0]       id_r;
        logic [`SBUS_ADDR_W-1:0]     addr_r;
        logic [`SBUS_DATA_W-1:0]     data_r;
        logic [`SBUS_WB_ADR_W-1:0]   pick;
        seed_val     = $urandom(22207);
        data_errors  = 0;
        end_errors   = 0;
        other_errors = 0;
        ops_issued   = 0;
        ends_seen    = 0;
        exp_end      = END_NONE;
        exp_data     = '0;
        exp_read     = 1'b0;
        rstn         = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        repeat (8) begin   // Idle bus after reset.
            @(posedge clk);
            if (wb_ack || wb_err) begin
                other_errors++;
                $display("ERROR %0t: ack or err seen with no cycle active", $time);
            end
            check_data(wb_dat_r, '0, "wb_dat_r after reset");
        end

        wb_access(sbus_pkg::OP_WRITE, 2'd1, 8'h3C, 8'hA5);
        wb_access(sbus_pkg::OP_READ, 2'd1, 8'h3C, '0);

        for (int n = 0; n < `SBUS_NUM_NODES; n++) begin
            wb_access(sbus_pkg::OP_WRITE, `SBUS_ID_W'(n), 8'h55, `SBUS_DATA_W'(8'h11 * (n + 1)));
        end
        for (int n = 0; n < `SBUS_NUM_NODES; n++) begin
            wb_access(sbus_pkg::OP_READ, `SBUS_ID_W'(n), 8'h55, '0);
        end

        wb_access(sbus_pkg::OP_READ, 2'd3, 8'h55, '0);
        wb_access(sbus_pkg::OP_WRITE, 2'd3, 8'h55, 8'hEE);
        wb_access(sbus_pkg::OP_READ, 2'd0, 8'h55, '0);

        for (int i = 0; i < 60; i++) begin
            id_r   = `SBUS_ID_W'($urandom_range(NUM_IDS - 1, 0));
            addr_r = `SBUS_ADDR_W'($urandom_range(DEPTH - 1, 0));
            data_r = `SBUS_DATA_W'($urandom_range(255, 0));
            if ($urandom_range(1, 0) == 1) begin
                if (id_r < `SBUS_NUM_NODES) begin
                    pick   = written_q[$urandom_range(written_q.size() - 1, 0)];
                    id_r   = pick[`SBUS_WB_ADR_W-1:`SBUS_ADDR_W];
                    addr_r = pick[`SBUS_ADDR_W-1:0];
                end
                wb_access(sbus_pkg::OP_READ, id_r, addr_r, '0);
            end else begin
                wb_access(sbus_pkg::OP_WRITE, id_r, addr_r, data_r);
            end
        end

        @(posedge clk);
        if (ends_seen != ops_issued) begin
            other_errors++;
            $display("ERROR: %0d cycles issued but %0d cycle ends checked", ops_issued, ends_seen);
        end
        $display("errors: data=%0d end=%0d other=%0d", data_errors, end_errors, other_errors);
        if (data_errors + end_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/sbus_pkg.sv
hw/sbus_frame_tx.sv
hw/sbus_node.sv
hw/sbus_resp_rx.sv
hw/sbus_top.sv
verification/sbus_sva.sv
verification/sbus_tb.sv
